// ==== common/fma_pkg.sv ====
// FMA package with the half-precision format constants, enums and payload structs
package fma_pkg;

  // --------------------------------------------------------------------------
  // Format and datapath widths
  // --------------------------------------------------------------------------
  localparam int EXP_BITS        = 5;
  localparam int MAN_BITS        = 10;
  localparam int FP_WIDTH        = 1 + EXP_BITS + MAN_BITS;
  localparam int BIAS            = 15;
  // Precision with the hidden bit
  localparam int PREC_BITS       = MAN_BITS + 1;
  // Addend, product and the round/sticky pair side by side
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;
  // Window searched for leading zeros after cancellation
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  // Signed internal exponent, wide enough for product overflow and underflow
  localparam int EXP_WIDTH       = EXP_BITS + 2;
  localparam int SHAMT_WIDTH     = 6;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } operation_e;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  typedef struct packed {
    logic NV;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef logic [3:0] tag_t;

  // --------------------------------------------------------------------------
  // Payloads between the pipeline parts
  // --------------------------------------------------------------------------
  typedef struct packed {
    fp_t        a;
    fp_t        b;
    fp_t        c;
    operation_e op;
    logic       op_mod;
    roundmode_e rnd_mode;
    tag_t       tag;
  } in_req_t;

  // Operands after the per-operation adjustment
  typedef struct packed {
    fp_t      a;
    fp_t      b;
    fp_t      c;
    fp_info_t info_a;
    fp_info_t info_b;
    fp_info_t info_c;
  } prep_t;

  typedef struct packed {
    logic    is_special;
    fp_t     result;
    status_t status;
  } special_t;

  typedef struct packed {
    logic                          eff_sub;
    logic signed [EXP_WIDTH-1:0]   exp_prod;
    logic signed [EXP_WIDTH-1:0]   exp_diff;
    logic signed [EXP_WIDTH-1:0]   tent_exp;
    logic        [SHAMT_WIDTH-1:0] addend_shamt;
    logic                          sticky_before_add;
    logic        [SUM_WIDTH-1:0]   sum;
    logic                          final_sign;
  } sum_t;

  typedef struct packed {
    sum_t       sum;
    special_t   special;
    roundmode_e rnd_mode;
    tag_t       tag;
  } mid_req_t;

  typedef struct packed {
    fp_t     result;
    status_t status;
    tag_t    tag;
  } fma_resp_t;

endpackage

// ==== source/fma_pipe_stage.sv ====
// Pipe stage that registers one payload of any type behind a valid/ready handshake
`timescale 1ns/1ps

module fma_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Take new data when the slot drains this cycle or holds a bubble
  assign ready_o = ready_i | ~valid_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves on an upstream handshake, so it stays put under stall
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

// ==== source/fma_operand_prep.sv ====
// Operand prep that classifies the three operands and applies the operation adjustment
`timescale 1ns/1ps

module fma_operand_prep import fma_pkg::*; (
  input  in_req_t req_i,
  output prep_t   prep_o
);

  // Class flags from the exponent and mantissa fields
  function automatic fp_info_t classify(fp_t op);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (op.exponent == '0);
    exp_ones           = (op.exponent == '1);
    man_zero           = (op.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  always_comb begin : op_adjust
    prep_o.a      = req_i.a;
    prep_o.b      = req_i.b;
    prep_o.c      = req_i.c;
    prep_o.info_a = classify(req_i.a);
    prep_o.info_b = classify(req_i.b);
    prep_o.info_c = classify(req_i.c);

    // op_mod always negates the addend
    prep_o.c.sign = req_i.c.sign ^ req_i.op_mod;

    case (req_i.op)
      // Negated product
      FNMSUB: prep_o.a.sign = ~req_i.a.sign;
      // Multiplier becomes +1.0
      ADD: begin
        prep_o.a      = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        prep_o.info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      // Addend becomes a zero that keeps the sign of a zero product
      MUL: begin
        prep_o.c      = '{sign: (req_i.rnd_mode != RDN), exponent: '0, mantissa: '0};
        prep_o.info_c = '{is_zero: 1'b1, default: 1'b0};
      end
      default: ;
    endcase
  end

endmodule

// ==== source/fma_special_cases.sv ====
// Special-case detector for NaN, infinity and invalid inputs with the bypass result
`timescale 1ns/1ps

module fma_special_cases import fma_pkg::*; (
  input  prep_t    prep_i,
  output special_t special_o
);

  logic any_inf;
  logic any_nan;
  logic any_snan;
  logic prod_inf;
  logic eff_sub;

  assign prod_inf = prep_i.info_a.is_inf | prep_i.info_b.is_inf;
  assign any_inf  = prod_inf | prep_i.info_c.is_inf;
  assign any_nan  = prep_i.info_a.is_nan | prep_i.info_b.is_nan | prep_i.info_c.is_nan;
  assign any_snan = prep_i.info_a.is_signalling | prep_i.info_b.is_signalling
                  | prep_i.info_c.is_signalling;
  // Product and addend carry opposite signs
  assign eff_sub  = prep_i.a.sign ^ prep_i.b.sign ^ prep_i.c.sign;

  always_comb begin : special_select
    // Canonical quiet NaN unless an infinity wins below
    special_o.is_special = 1'b0;
    special_o.result     = '{sign: 1'b0, exponent: '1, mantissa: 10'h200};
    special_o.status     = '0;

    // inf * 0 is invalid even with a quiet NaN addend
    if ((prep_i.info_a.is_inf && prep_i.info_b.is_zero)
        || (prep_i.info_a.is_zero && prep_i.info_b.is_inf)) begin
      special_o.is_special = 1'b1;
      special_o.status.NV  = 1'b1;
    end else if (any_nan) begin
      special_o.is_special = 1'b1;
      special_o.status.NV  = any_snan;
    end else if (any_inf) begin
      special_o.is_special = 1'b1;
      if (prod_inf && prep_i.info_c.is_inf && eff_sub) begin
        // inf - inf
        special_o.status.NV = 1'b1;
      end else if (prod_inf) begin
        special_o.result = '{sign: prep_i.a.sign ^ prep_i.b.sign, exponent: '1, mantissa: '0};
      end else begin
        special_o.result = '{sign: prep_i.c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

// ==== fma_datapath/fma_sum_path.sv ====
// Sum path with exponent arithmetic, mantissa product, addend alignment and the wide add
`timescale 1ns/1ps

module fma_sum_path import fma_pkg::*; (
  input  prep_t prep_i,
  output sum_t  sum_o
);

  logic                            eff_sub;
  logic                            tent_sign;
  logic signed [EXP_WIDTH-1:0]     exp_a, exp_b, exp_c;
  logic signed [EXP_WIDTH-1:0]     exp_addend, exp_prod, exp_diff;
  logic        [SHAMT_WIDTH-1:0]   addend_shamt;
  logic        [PREC_BITS-1:0]     man_a, man_b, man_c;
  logic        [2*PREC_BITS-1:0]   product;
  logic        [SUM_WIDTH-1:0]     product_shifted;
  // Aligned addend followed by the bits that fall off into the sticky
  logic [SUM_WIDTH+PREC_BITS-1:0]  addend_wide;
  logic        [SUM_WIDTH-1:0]     addend_shifted;
  logic                            sticky;
  logic        [SUM_WIDTH:0]       sum_raw;

  assign eff_sub   = prep_i.a.sign ^ prep_i.b.sign ^ prep_i.c.sign;
  assign tent_sign = prep_i.a.sign ^ prep_i.b.sign;

  // --------------------------------------------------------------------------
  // Exponents, kept biased
  // --------------------------------------------------------------------------
  assign exp_a = {2'b00, prep_i.a.exponent};
  assign exp_b = {2'b00, prep_i.b.exponent};
  assign exp_c = {2'b00, prep_i.c.exponent};

  // Subnormals and zeros sit at encoded exponent 1
  assign exp_addend = exp_c + EXP_WIDTH'(!prep_i.info_c.is_normal);
  // Zero product gets the smallest exponent so it never anchors
  assign exp_prod   = (prep_i.info_a.is_zero || prep_i.info_b.is_zero)
                    ? EXP_WIDTH'(2 - BIAS)
                    : exp_a + EXP_WIDTH'(prep_i.info_a.is_subnormal)
                      + exp_b + EXP_WIDTH'(prep_i.info_b.is_subnormal) - EXP_WIDTH'(BIAS);
  assign exp_diff   = exp_addend - exp_prod;

  always_comb begin : addend_shift
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      // Addend lands entirely in the sticky bit
      addend_shamt = SHAMT_WIDTH'(3 * PREC_BITS + 4);
    end else if (exp_diff <= PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff);
    end else begin
      // Product far below the addend
      addend_shamt = '0;
    end
  end

  // --------------------------------------------------------------------------
  // Mantissas, alignment and addition
  // --------------------------------------------------------------------------
  assign man_a = {prep_i.info_a.is_normal, prep_i.a.mantissa};
  assign man_b = {prep_i.info_b.is_normal, prep_i.b.mantissa};
  assign man_c = {prep_i.info_c.is_normal, prep_i.c.mantissa};

  assign product         = man_a * man_b;
  // Two low bits left free for round and sticky
  assign product_shifted = SUM_WIDTH'(product) << 2;

  assign addend_wide    = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky         = |addend_wide[PREC_BITS-1:0];
  assign addend_shifted = addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS] ^ {SUM_WIDTH{eff_sub}};

  // Carry-in completes the two's complement only when nothing was shifted out
  assign sum_raw = {1'b0, product_shifted} + {1'b0, addend_shifted}
                 + (SUM_WIDTH+1)'(eff_sub & ~sticky);

  assign sum_o.eff_sub           = eff_sub;
  assign sum_o.exp_prod          = exp_prod;
  assign sum_o.exp_diff          = exp_diff;
  assign sum_o.tent_exp          = (exp_diff > 0) ? exp_addend : exp_prod;
  assign sum_o.addend_shamt      = addend_shamt;
  assign sum_o.sticky_before_add = sticky;
  // No carry on a subtraction means the addend was larger
  assign sum_o.sum               = (eff_sub && !sum_raw[SUM_WIDTH])
                                 ? -sum_raw[SUM_WIDTH-1:0] : sum_raw[SUM_WIDTH-1:0];
  assign sum_o.final_sign        = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

endmodule

// ==== fma_datapath/fma_norm_round.sv ====
// Normalize-and-round stage that forms the rounded result, flags and special select
`timescale 1ns/1ps

module fma_norm_round import fma_pkg::*; (
  input  mid_req_t  mid_i,
  output fma_resp_t resp_o
);

  logic signed [EXP_WIDTH-1:0]         exp_prod, exp_diff, tent_exp;
  logic        [LOWER_SUM_WIDTH-1:0]   sum_lower;
  logic        [SHAMT_WIDTH-1:0]       lzc;
  logic signed [EXP_WIDTH-1:0]         lzc_sgn;
  logic                                lzc_zero;
  logic        [SHAMT_WIDTH-1:0]       norm_shamt;
  logic signed [EXP_WIDTH-1:0]         norm_exp, final_exp;
  logic        [SUM_WIDTH:0]           sum_shifted;
  // Hidden bit, stored mantissa and round bit
  logic        [PREC_BITS:0]           final_man;
  logic        [LOWER_SUM_WIDTH-1:0]   sticky_bits;
  logic                                sticky_after_norm;
  logic                                of_before, of_after;
  logic        [EXP_BITS-1:0]          pre_exp;
  logic        [MAN_BITS-1:0]          pre_man;
  logic        [EXP_BITS+MAN_BITS-1:0] pre_abs, rounded_abs;
  logic        [1:0]                   rs;
  logic                                round_up;
  logic                                exact_zero;
  logic                                rounded_sign;
  logic        [FP_WIDTH-1:0]          regular_result;
  status_t                             regular_status;

  assign exp_prod  = mid_i.sum.exp_prod;
  assign exp_diff  = mid_i.sum.exp_diff;
  assign tent_exp  = mid_i.sum.tent_exp;
  assign sum_lower = mid_i.sum.sum[LOWER_SUM_WIDTH-1:0];

  // --------------------------------------------------------------------------
  // Normalization
  // --------------------------------------------------------------------------
  // Highest set bit is seen last and wins
  always_comb begin : lzc_count
    lzc = '0;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum_lower[i]) lzc = SHAMT_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
    end
  end

  assign lzc_zero = ~|sum_lower;
  assign lzc_sgn  = {1'b0, lzc};

  always_comb begin : norm_shift
    if ((exp_diff <= 0) || (mid_i.sum.eff_sub && (exp_diff <= 2))) begin
      // Product anchored or heavy cancellation
      if ((exp_prod - lzc_sgn + 1 >= 0) && !lzc_zero) begin
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2) + lzc;
        norm_exp   = exp_prod - lzc_sgn + EXP_WIDTH'(1);
      end else begin
        // Subnormal result, shift only down to the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = mid_i.sum.addend_shamt;
      norm_exp   = tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum.sum} << norm_shamt;

  // Leading one may still sit one place off the hidden-bit position
  always_comb begin : small_norm
    {final_man, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + EXP_WIDTH'(1);
    end else if (!sum_shifted[SUM_WIDTH-1]) begin
      if (norm_exp > 1) begin
        {final_man, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
        final_exp                = norm_exp - EXP_WIDTH'(1);
      end else begin
        final_exp = '0;
      end
    end
  end

  // Bit 0 also covers the one dropped by the right shift
  assign sticky_after_norm = (|sticky_bits) | sum_shifted[0] | mid_i.sum.sticky_before_add;

  // --------------------------------------------------------------------------
  // Rounding
  // --------------------------------------------------------------------------
  assign of_before = final_exp >= (2 ** EXP_BITS) - 1;
  // Overflow saturates to max finite and rounding decides about infinity
  assign pre_exp   = of_before ? EXP_BITS'(2 ** EXP_BITS - 2) : final_exp[EXP_BITS-1:0];
  assign pre_man   = of_before ? '1 : final_man[MAN_BITS:1];
  assign pre_abs   = {pre_exp, pre_man};
  assign rs        = of_before ? 2'b11 : {final_man[0], sticky_after_norm};

  always_comb begin : round_decision
    case (mid_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs) & mid_i.sum.final_sign;
      RUP:     round_up = (|rs) & ~mid_i.sum.final_sign;
      RMM:     round_up = rs[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry rolls into the exponent
  assign rounded_abs = pre_abs + (EXP_BITS+MAN_BITS)'(round_up);
  assign of_after    = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);

  // Exact cancellation gives +0, or -0 when rounding down
  assign exact_zero   = (pre_abs == '0) && (rs == 2'b00);
  assign rounded_sign = (exact_zero && mid_i.sum.eff_sub) ? (mid_i.rnd_mode == RDN)
                                                          : mid_i.sum.final_sign;

  assign regular_result    = {rounded_sign, rounded_abs};
  assign regular_status.NV = 1'b0;
  assign regular_status.OF = of_before | of_after;
  assign regular_status.NX = (|rs) | of_before | of_after;
  // Tiny when below the smallest normal before rounding
  assign regular_status.UF = (final_exp == '0) & regular_status.NX;

  assign resp_o.result = mid_i.special.is_special ? mid_i.special.result : regular_result;
  assign resp_o.status = mid_i.special.is_special ? mid_i.special.status : regular_status;
  assign resp_o.tag    = mid_i.tag;

endmodule

// ==== source/fma_top.sv ====
// Half-precision FMA top with an input stage, the parallel datapath and a middle stage
`timescale 1ns/1ps

module fma_top import fma_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request side
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  in_req_t   req_i,
  // Response side
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output fma_resp_t resp_o
);

  logic     inp_valid;
  logic     inp_ready;
  in_req_t  inp_req;
  prep_t    prep;
  special_t special;
  sum_t     sum;
  mid_req_t mid_d;
  mid_req_t mid_q;

  // --------------------------------------------------------------------------
  // Stage one holds the raw request
  // --------------------------------------------------------------------------
  fma_pipe_stage #(
    .payload_t ( in_req_t )
  ) in_stage (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_i  ( req_i      ),
    .valid_o ( inp_valid  ),
    .ready_i ( inp_ready  ),
    .data_o  ( inp_req    )
  );

  fma_operand_prep u_prep (
    .req_i  ( inp_req ),
    .prep_o ( prep    )
  );

  // Special cases and the sum work side by side on the same operands
  fma_special_cases u_special (
    .prep_i    ( prep    ),
    .special_o ( special )
  );

  fma_sum_path u_sum (
    .prep_i ( prep ),
    .sum_o  ( sum  )
  );

  assign mid_d.sum      = sum;
  assign mid_d.special  = special;
  assign mid_d.rnd_mode = inp_req.rnd_mode;
  assign mid_d.tag      = inp_req.tag;

  // --------------------------------------------------------------------------
  // Stage two feeds normalize and round
  // --------------------------------------------------------------------------
  fma_pipe_stage #(
    .payload_t ( mid_req_t )
  ) mid_stage (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .valid_i ( inp_valid   ),
    .ready_o ( inp_ready   ),
    .data_i  ( mid_d       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( mid_q       )
  );

  fma_norm_round u_norm_round (
    .mid_i  ( mid_q  ),
    .resp_o ( resp_o )
  );

endmodule

// ==== tb/fma_tb.sv ====
// Testbench for the half-precision FMA with random stimulus and an exact integer model
`timescale 1ns/1ps

module fma_tb import fma_pkg::*; ();

  localparam int NUM_OPS    = 3000;
  localparam int HALF_OPS   = NUM_OPS / 2;
  localparam int MAX_CYCLES = 4 * NUM_OPS + 100;

  logic      clk_i;
  logic      rst_n_i;
  logic      in_valid_i;
  logic      in_ready_o;
  in_req_t   req_i;
  logic      out_valid_o;
  logic      out_ready_i;
  fma_resp_t resp_o;

  // Scoreboard with the acceptance cycle of each request
  fma_resp_t exp_q[$];
  int        cyc_q[$];
  int        errors     = 0;
  int        received   = 0;
  int        cycle      = 0;
  bit        stall_mode = 1'b0;

  fma_top dut0 (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .req_i       ( req_i       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .resp_o      ( resp_o      )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic is_nan(fp_t x);
    return (x.exponent == '1) && (x.mantissa != '0);
  endfunction

  function automatic logic is_snan(fp_t x);
    return is_nan(x) && !x.mantissa[MAN_BITS-1];
  endfunction

  function automatic logic is_inf(fp_t x);
    return (x.exponent == '1) && (x.mantissa == '0);
  endfunction

  function automatic logic is_zero(fp_t x);
    return (x.exponent == '0) && (x.mantissa == '0);
  endfunction

  // Magnitude of a finite operand times 2^24 as an exact integer
  function automatic logic [127:0] to_scaled_int(fp_t x);
    logic [127:0] sig;
    int           e_eff;
    sig   = {117'd0, (x.exponent != '0), x.mantissa};
    e_eff = (x.exponent == '0) ? 1 : int'(x.exponent);
    return sig << (e_eff - 1);
  endfunction

  function automatic fma_resp_t expected_response(in_req_t req);
    fp_t          a, b, c;
    fma_resp_t    r;
    logic         ps, cs, res_sign, inf_prod, inc, to_inf;
    logic [127:0] pm, cm, m, q, rem, half;
    int           p, e, sh;
    longint       abs_val;
    a = req.a;
    b = req.b;
    c = req.c;
    c.sign = c.sign ^ req.op_mod;
    case (req.op)
      FNMSUB: a.sign = ~a.sign;
      ADD:    a = 16'h3C00;
      MUL:    c = (req.rnd_mode == RDN) ? 16'h0000 : 16'h8000;
      default: ;
    endcase
    r.tag    = req.tag;
    r.status = '0;
    r.result = 16'h7E00;
    ps       = a.sign ^ b.sign;
    cs       = c.sign;
    inf_prod = is_inf(a) | is_inf(b);

    // Bypass cases in priority order
    if ((is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b))) begin
      r.status.NV = 1'b1;
      return r;
    end
    if (is_nan(a) || is_nan(b) || is_nan(c)) begin
      r.status.NV = is_snan(a) | is_snan(b) | is_snan(c);
      return r;
    end
    if (inf_prod && is_inf(c) && (ps != cs)) begin
      r.status.NV = 1'b1;
      return r;
    end
    if (inf_prod || is_inf(c)) begin
      r.result = {inf_prod ? ps : cs, 15'h7C00};
      return r;
    end

    // Exact signed sum in units of 2^-48
    pm = to_scaled_int(a) * to_scaled_int(b);
    cm = to_scaled_int(c) << 24;
    if (ps == cs) begin
      m        = pm + cm;
      res_sign = ps;
    end else if (pm >= cm) begin
      m        = pm - cm;
      res_sign = ps;
    end else begin
      m        = cm - pm;
      res_sign = cs;
    end
    if (m == 0) begin
      r.result = {(ps == cs) ? ps : (req.rnd_mode == RDN), 15'd0};
      return r;
    end

    // Result exponent from the leading one with a floor at the subnormal range
    p = 0;
    for (int i = 0; i < 128; i++) begin
      if (m[i]) p = i;
    end
    e    = (p - 33 < 1) ? 1 : p - 33;
    sh   = e + 23;
    q    = m >> sh;
    rem  = m & ((128'd1 << sh) - 128'd1);
    half = 128'd1 << (sh - 1);
    case (req.rnd_mode)
      RNE:     inc = (rem > half) || ((rem == half) && q[0]);
      RDN:     inc = (rem != 0) && res_sign;
      RUP:     inc = (rem != 0) && !res_sign;
      RMM:     inc = (rem >= half);
      default: inc = 1'b0;
    endcase
    // Mantissa carry rolls into the exponent field by itself
    abs_val = longint'(e - 1) * 1024 + longint'(q[31:0]) + longint'(inc);

    if (abs_val >= 64'h7C00) begin
      r.status.OF = 1'b1;
      r.status.NX = 1'b1;
      case (req.rnd_mode)
        RTZ:     to_inf = 1'b0;
        RDN:     to_inf = res_sign;
        RUP:     to_inf = !res_sign;
        default: to_inf = 1'b1;
      endcase
      r.result = {res_sign, to_inf ? 15'h7C00 : 15'h7BFF};
    end else begin
      r.result    = {res_sign, abs_val[14:0]};
      r.status.NX = (rem != 0);
      // Tiny means below 2^-14 before rounding
      r.status.UF = (m < (128'd1 << 34)) && (rem != 0);
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Operand class mix weighted toward corner cases
  function automatic fp_t random_operand();
    fp_t x;
    int  cls;
    cls        = int'($urandom % 16);
    x.sign     = 1'($urandom % 2);
    x.mantissa = 10'($urandom);
    if (cls < 6) begin
      x.exponent = 5'(1 + $urandom % 30);
    end else if (cls < 9) begin
      x.exponent = 5'(12 + $urandom % 7);
    end else if (cls == 9) begin
      x.exponent = '0;
      x.mantissa = '0;
    end else if (cls < 12) begin
      x.exponent = '0;
      if (x.mantissa == '0) x.mantissa = 10'd1;
    end else if (cls == 12) begin
      x.exponent = '1;
      x.mantissa = '0;
    end else if (cls == 13) begin
      x.exponent = '1;
      x.mantissa[MAN_BITS-1] = 1'($urandom % 2);
      if (x.mantissa == '0) x.mantissa = 10'd1;
    end else begin
      x.exponent = 5'(28 + $urandom % 3);
    end
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #5;
    out_ready_i = stall_mode ? ($urandom % 3 != 0) : 1'b1;
  endtask

  // Hold the request until the DUT takes it
  task automatic send_op(input in_req_t req);
    logic taken;
    in_valid_i = 1'b1;
    req_i      = req;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
    end
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) next_cycle();
  endtask

  // --------------------------------------------------------------------------
  // Monitor sampled at the falling edge where all signals are settled
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : monitor
    fma_resp_t expected;
    int        in_cycle;
    if (rst_n_i) begin
      // Without back-pressure the unit takes a request every cycle
      if (!stall_mode) check_value("in_ready_o", 32'(in_ready_o), 32'd1);
      // Pop before push so a same-cycle request is not matched
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response seen with no request outstanding");
        end else begin
          expected = exp_q.pop_front();
          in_cycle = cyc_q.pop_front();
          received++;
          check_value("resp_o.result", 32'(resp_o.result), 32'(expected.result));
          check_value("resp_o.status", 32'(resp_o.status), 32'(expected.status));
          check_value("resp_o.tag", 32'(resp_o.tag), 32'(expected.tag));
          if (!stall_mode) check_value("latency", 32'(cycle - in_cycle), 32'd2);
        end
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(expected_response(req_i));
        cyc_q.push_back(cycle);
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses still outstanding",
               cycle, exp_q.size());
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    in_req_t req;
    void'($urandom(95923));
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    next_cycle();

    // First half at full rate and second half with random back-pressure and gaps
    for (int sent = 0; sent < NUM_OPS; sent++) begin
      if (sent == HALF_OPS) begin
        drain();
        stall_mode = 1'b1;
      end
      if (stall_mode && ($urandom % 4 == 0)) next_cycle();
      req.a = random_operand();
      req.b = random_operand();
      req.c = random_operand();
      // Occasional exact cancellation against b
      if ($urandom % 16 == 0) req.c = {~req.b.sign, req.b.exponent, req.b.mantissa};
      req.op       = operation_e'($urandom % 4);
      req.op_mod   = 1'($urandom % 2);
      req.rnd_mode = roundmode_e'($urandom % 5);
      req.tag      = 4'(sent);
      send_op(req);
    end
    drain();
    if (received != NUM_OPS) begin
      errors++;
      $display("Only %0d of %0d responses were received", received, NUM_OPS);
    end

    $display("Errors: %0d, responses checked: %0d", errors, received);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
common/fma_pkg.sv
source/fma_pipe_stage.sv
source/fma_operand_prep.sv
source/fma_special_cases.sv
fma_datapath/fma_sum_path.sv
fma_datapath/fma_norm_round.sv
source/fma_top.sv
tb/fma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the FMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module fma_tb -o fma_sim

out=$(./obj_dir/fma_sim)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1
